// File: verilog/link_pkg.sv
package link_pkg;

    // command byte sent by the MCU at the start of every frame.
    typedef enum logic [7:0] {
        CMD_IDENTIFY  = 8'd0,
        CMD_REG_READ  = 8'd1,
        CMD_REG_WRITE = 8'd2,
        CMD_MEM_READ  = 8'd3,
        CMD_MEM_WRITE = 8'd4
    } cmd_e;

    typedef enum logic [1:0] {
        PHASE_CMD,
        PHASE_ADDRESS,
        PHASE_DATA,
        PHASE_IDLE     // frame ignored until the next chip select.
    } phase_e;

    localparam logic [7:0] DEVICE_ID = 8'h64;

    typedef enum logic [7:0] {
        REG_STATUS      = 8'd0,
        REG_MEM_ADDRESS = 8'd1,
        REG_MEM_SCR     = 8'd2
    } reg_addr_e;

endpackage

// File: verilog/buffer_pkg.sv
package buffer_pkg;

    localparam int BUF_ADDR_W = 9;
    localparam int BUF_DEPTH  = 1 << BUF_ADDR_W;
    localparam int WORD_W     = 16;
    localparam int BUS_ADDR_W = 32;  // byte address, words sit at even addresses.

    // MEM_SCR layout.
    // The write word carries start, stop, direction and the length in words.
    // The read word only reports busy.
    localparam int START_BIT = 0;
    localparam int STOP_BIT  = 1;
    localparam int DIR_BIT   = 2;  // 1 copies the buffer out to the bus.
    localparam int BUSY_BIT  = 3;
    localparam int LEN_LSB   = 5;
    localparam int LEN_MSB   = 14;

endpackage

// File: verilog/mcu_spi.sv
`timescale 1ns/1ps

module mcu_spi #(
    parameter int SYNC_STAGES = 2
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       mcu_clk,
    input  logic       mcu_cs,
    input  logic       mcu_mosi,
    output logic       mcu_miso,
    output logic       frame_start,
    output logic       data_ready,
    output logic [7:0] rx_data,
    input  logic [7:0] tx_data
);
    logic [SYNC_STAGES-1:0] sck_ff;
    logic [SYNC_STAGES-1:0] cs_ff;
    logic [SYNC_STAGES-1:0] mosi_ff;
    logic                   sck_q;
    logic                   cs_q;
    logic                   sck_rise;
    logic                   sck_fall;
    logic                   cs_active;
    logic [2:0]             bit_cnt;
    logic [7:0]             rx_shift;
    logic [7:0]             tx_shift;
    logic [7:0]             reload_dly;

    assign sck_rise  = sck_ff[SYNC_STAGES-1] && !sck_q;
    assign sck_fall  = !sck_ff[SYNC_STAGES-1] && sck_q;
    assign cs_active = !cs_ff[SYNC_STAGES-1];
    assign rx_data   = rx_shift;  // stable until the next rising edge.
    assign mcu_miso  = tx_shift[7];

    always_ff @(posedge clk) begin
        mosi_ff <= {mosi_ff[SYNC_STAGES-2:0], mcu_mosi};
        if (cs_active && sck_rise) begin
            rx_shift <= {rx_shift[6:0], mosi_ff[SYNC_STAGES-1]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sck_ff      <= '0;
            cs_ff       <= '1;
            sck_q       <= 1'b0;
            cs_q        <= 1'b1;
            frame_start <= 1'b0;
            data_ready  <= 1'b0;
            bit_cnt     <= 3'd0;
            tx_shift    <= 8'h00;
            reload_dly  <= 8'h00;
        end else begin
            sck_ff      <= {sck_ff[SYNC_STAGES-2:0], mcu_clk};
            cs_ff       <= {cs_ff[SYNC_STAGES-2:0], mcu_cs};
            sck_q       <= sck_ff[SYNC_STAGES-1];
            cs_q        <= cs_ff[SYNC_STAGES-1];
            frame_start <= cs_q && cs_active;
            data_ready  <= 1'b0;
            reload_dly  <= {reload_dly[6:0], data_ready};

            if (!cs_active) begin
                bit_cnt <= 3'd0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 1'b1;
                data_ready <= (bit_cnt == 3'd7);
            end

            // the reply byte is taken 8 cycles after each received byte,
            // which leaves the protocol time to fetch it.
            if (frame_start || reload_dly[7]) begin
                tx_shift <= tx_data;
            end else if (cs_active && sck_fall) begin
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

endmodule

// File: verilog/link_protocol.sv
`timescale 1ns/1ps

module link_protocol
    import link_pkg::*;
    import buffer_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  frame_start,
    input  logic                  data_ready,
    input  logic [7:0]            rx_data,
    output logic [7:0]            tx_data,
    output logic                  reg_read,
    output logic                  reg_write,
    output logic [7:0]            reg_addr,
    output logic [31:0]           reg_wdata,
    input  logic [31:0]           reg_rdata,
    output logic                  buf_req,
    output logic                  buf_we,
    output logic [BUF_ADDR_W-1:0] buf_addr,
    output logic [WORD_W-1:0]     buf_wdata,
    input  logic                  buf_ack,
    input  logic [WORD_W-1:0]     buf_rdata
);
    phase_e            phase;
    cmd_e              cmd;
    logic [1:0]        counter;   // byte position within the data word.
    logic              buf_pend;  // access waiting for the previous ack to clear.
    logic [WORD_W-1:0] rd_word;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase     <= PHASE_IDLE;
            cmd       <= CMD_IDENTIFY;
            counter   <= 2'd0;
            reg_read  <= 1'b0;
            reg_write <= 1'b0;
            buf_req   <= 1'b0;
            buf_pend  <= 1'b0;
        end else begin
            reg_read  <= 1'b0;
            reg_write <= 1'b0;

            if (reg_read || reg_write) begin
                reg_addr <= reg_addr + 1'b1;
            end

            if (buf_req && buf_ack) begin
                buf_req  <= 1'b0;
                buf_addr <= buf_addr + 1'b1;
                if (!buf_we) begin
                    rd_word <= buf_rdata;
                end
            end else if (buf_pend && !buf_req && !buf_ack) begin
                buf_req  <= 1'b1;
                buf_pend <= 1'b0;
            end

            if (frame_start) begin
                phase   <= PHASE_CMD;
                counter <= 2'd0;
            end else if (data_ready) begin
                case (phase)
                    PHASE_CMD: begin
                        cmd   <= cmd_e'(rx_data);
                        phase <= (rx_data > CMD_MEM_WRITE) ? PHASE_IDLE : PHASE_ADDRESS;
                    end
                    PHASE_ADDRESS: begin
                        phase    <= PHASE_DATA;
                        reg_addr <= rx_data;
                        buf_addr <= {rx_data, 1'b0};  // one address step is two words.
                        reg_read <= (cmd == CMD_REG_READ);
                        if (cmd == CMD_MEM_READ) begin
                            buf_pend <= 1'b1;
                            buf_we   <= 1'b0;
                        end
                    end
                    PHASE_DATA: begin
                        counter <= counter + 1'b1;
                        case (cmd)
                            CMD_REG_READ: begin
                                reg_read <= (counter == 2'd3);
                            end
                            CMD_REG_WRITE: begin
                                reg_wdata[{counter, 3'b000} +: 8] <= rx_data;
                                reg_write <= (counter == 2'd3);
                            end
                            CMD_MEM_READ: begin
                                if (counter[0]) begin
                                    buf_pend <= 1'b1;
                                    buf_we   <= 1'b0;
                                end
                            end
                            CMD_MEM_WRITE: begin
                                if (counter[0]) begin
                                    buf_wdata[7:0] <= rx_data;
                                    buf_pend       <= 1'b1;
                                    buf_we         <= 1'b1;
                                end else begin
                                    buf_wdata[15:8] <= rx_data;
                                end
                            end
                            default: begin
                            end
                        endcase
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        case (cmd)
            CMD_IDENTIFY: tx_data = DEVICE_ID;
            CMD_REG_READ: tx_data = reg_rdata[{counter, 3'b000} +: 8];
            CMD_MEM_READ: tx_data = counter[0] ? rd_word[7:0] : rd_word[15:8];
            default:      tx_data = 8'h00;
        endcase
    end

endmodule

// File: verilog/link_registers.sv
`timescale 1ns/1ps

module link_registers
    import link_pkg::*;
    import buffer_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  sd_det,
    input  logic                  button,
    input  logic                  reg_read,
    input  logic                  reg_write,
    input  logic [7:0]            reg_addr,
    input  logic [31:0]           reg_wdata,
    output logic [31:0]           reg_rdata,
    output logic                  dma_start,
    output logic                  dma_stop,
    output logic                  dma_write,
    output logic [BUF_ADDR_W-1:0] dma_last,
    output logic [BUS_ADDR_W-1:0] dma_address,
    input  logic                  dma_busy
);
    logic [SYNC_STAGES-1:0]   sd_det_ff;
    logic [SYNC_STAGES-1:0]   button_ff;
    logic [LEN_MSB-LEN_LSB:0] length_m1;

    assign length_m1 = reg_wdata[LEN_MSB:LEN_LSB] - 1'b1;

    always_ff @(posedge clk) begin
        sd_det_ff <= {sd_det_ff[SYNC_STAGES-2:0], sd_det};
        button_ff <= {button_ff[SYNC_STAGES-2:0], button};
    end

    always_ff @(posedge clk) begin
        if (reg_read) begin
            case (reg_addr)
                REG_STATUS: begin
                    // both inputs are active low on the board.
                    reg_rdata <= {30'd0, ~sd_det_ff[SYNC_STAGES-1], ~button_ff[SYNC_STAGES-1]};
                end
                REG_MEM_ADDRESS: reg_rdata <= dma_address;
                REG_MEM_SCR:     reg_rdata <= 32'(dma_busy) << BUSY_BIT;
                default:         reg_rdata <= 32'd0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dma_start <= 1'b0;
            dma_stop  <= 1'b0;
            dma_write <= 1'b0;
            dma_last  <= '0;
        end else begin
            dma_start <= 1'b0;
            dma_stop  <= 1'b0;
            if (reg_write) begin
                case (reg_addr)
                    REG_MEM_ADDRESS: dma_address <= reg_wdata;
                    REG_MEM_SCR: begin
                        dma_stop <= reg_wdata[STOP_BIT];
                        // direction and length stay fixed while a transfer runs.
                        if (!dma_busy) begin
                            dma_start <= reg_wdata[START_BIT];
                            dma_write <= reg_wdata[DIR_BIT];
                            dma_last  <= length_m1[BUF_ADDR_W-1:0];
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// File: verilog/buffer_arbiter.sv
`timescale 1ns/1ps

module buffer_arbiter
    import buffer_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  a_req,
    input  logic                  a_we,
    input  logic [BUF_ADDR_W-1:0] a_addr,
    input  logic [WORD_W-1:0]     a_wdata,
    output logic                  a_ack,
    output logic [WORD_W-1:0]     a_rdata,
    input  logic                  b_req,
    input  logic                  b_we,
    input  logic [BUF_ADDR_W-1:0] b_addr,
    input  logic [WORD_W-1:0]     b_wdata,
    output logic                  b_ack,
    output logic [WORD_W-1:0]     b_rdata
);
    logic [WORD_W-1:0]     mem [BUF_DEPTH];
    logic [WORD_W-1:0]     rdata_q;
    logic                  prio_b;  // port b wins the next conflict.
    logic                  idle;
    logic                  grant_a;
    logic                  grant_b;
    logic [BUF_ADDR_W-1:0] acc_addr;
    logic                  acc_we;
    logic [WORD_W-1:0]     acc_wdata;

    // a new grant waits until both acks are low again.
    assign idle      = !a_ack && !b_ack;
    assign grant_a   = idle && a_req && (!b_req || !prio_b);
    assign grant_b   = idle && b_req && !grant_a;
    assign acc_addr  = grant_b ? b_addr : a_addr;
    assign acc_we    = grant_b ? b_we : a_we;
    assign acc_wdata = grant_b ? b_wdata : a_wdata;
    assign a_rdata   = rdata_q;
    assign b_rdata   = rdata_q;

    always_ff @(posedge clk) begin
        if (grant_a || grant_b) begin
            if (acc_we) begin
                mem[acc_addr] <= acc_wdata;
            end
            rdata_q <= mem[acc_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            a_ack  <= 1'b0;
            b_ack  <= 1'b0;
            prio_b <= 1'b0;
        end else begin
            if (grant_a) begin
                a_ack  <= 1'b1;
                prio_b <= 1'b1;
            end else if (!a_req) begin
                a_ack <= 1'b0;
            end
            if (grant_b) begin
                b_ack  <= 1'b1;
                prio_b <= 1'b0;
            end else if (!b_req) begin
                b_ack <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/mem_bus_dma.sv
`timescale 1ns/1ps

module mem_bus_dma
    import buffer_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  dma_start,
    input  logic                  dma_stop,
    input  logic                  dma_write,
    input  logic [BUF_ADDR_W-1:0] dma_last,
    input  logic [BUS_ADDR_W-1:0] dma_address,
    output logic                  dma_busy,
    output logic                  buf_req,
    output logic                  buf_we,
    output logic [BUF_ADDR_W-1:0] buf_addr,
    output logic [WORD_W-1:0]     buf_wdata,
    input  logic                  buf_ack,
    input  logic [WORD_W-1:0]     buf_rdata,
    output logic                  mem_request,
    output logic                  mem_write,
    output logic [BUS_ADDR_W-1:0] mem_address,
    output logic [WORD_W-1:0]     mem_wdata,
    input  logic                  mem_ack,
    input  logic [WORD_W-1:0]     mem_rdata
);
    typedef enum logic [1:0] {
        S_IDLE,
        S_BUF,
        S_BUS
    } state_e;

    state_e state;
    logic   stop_pending;
    logic   last_word;

    assign buf_we    = !mem_write;  // a bus read fills the buffer.
    assign last_word = (buf_addr == dma_last) || stop_pending || dma_stop;

    // buf_addr doubles as the word counter of the transfer.
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= S_IDLE;
            dma_busy     <= 1'b0;
            stop_pending <= 1'b0;
            buf_req      <= 1'b0;
            mem_request  <= 1'b0;
        end else begin
            if (dma_stop && dma_busy) begin
                stop_pending <= 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (dma_start && !dma_stop) begin
                        dma_busy     <= 1'b1;
                        stop_pending <= 1'b0;
                        buf_addr     <= '0;
                        mem_write    <= dma_write;
                        mem_address  <= dma_address;
                        state        <= dma_write ? S_BUF : S_BUS;
                    end
                end
                S_BUF: begin
                    if (buf_req && buf_ack) begin
                        buf_req   <= 1'b0;
                        mem_wdata <= buf_rdata;
                        if (mem_write) begin
                            state <= S_BUS;
                        end else if (!dma_busy) begin
                            state <= S_IDLE;  // last word of a bus read is now stored.
                        end else begin
                            buf_addr <= buf_addr + 1'b1;
                            state    <= S_BUS;
                        end
                    end else if (!buf_req && !buf_ack) begin
                        buf_req <= 1'b1;
                    end
                end
                S_BUS: begin
                    if (mem_request && mem_ack) begin
                        mem_request <= 1'b0;
                        mem_address <= mem_address + BUS_ADDR_W'(2);
                        buf_wdata   <= mem_rdata;
                        if (last_word) begin
                            dma_busy <= 1'b0;
                        end
                        if (!mem_write) begin
                            state <= S_BUF;
                        end else if (last_word) begin
                            state <= S_IDLE;
                        end else begin
                            buf_addr <= buf_addr + 1'b1;
                            state    <= S_BUF;
                        end
                    end else if (!mem_request && !mem_ack) begin
                        mem_request <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: verilog/mcu_top.sv
`timescale 1ns/1ps

module mcu_top
    import buffer_pkg::*;
#(
    parameter int SYNC_STAGES = 3
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  sd_det,
    input  logic                  button,
    input  logic                  mcu_clk,
    input  logic                  mcu_cs,
    input  logic                  mcu_mosi,
    output logic                  mcu_miso,
    output logic                  mem_request,
    output logic                  mem_write,
    output logic [BUS_ADDR_W-1:0] mem_address,
    output logic [WORD_W-1:0]     mem_wdata,
    input  logic                  mem_ack,
    input  logic [WORD_W-1:0]     mem_rdata
);
    logic                  frame_start;
    logic                  data_ready;
    logic [7:0]            rx_data;
    logic [7:0]            tx_data;

    logic                  reg_read;
    logic                  reg_write;
    logic [7:0]            reg_addr;
    logic [31:0]           reg_wdata;
    logic [31:0]           reg_rdata;

    logic                  dma_start;
    logic                  dma_stop;
    logic                  dma_write;
    logic [BUF_ADDR_W-1:0] dma_last;
    logic [BUS_ADDR_W-1:0] dma_address;
    logic                  dma_busy;

    // port a belongs to the protocol controller, port b to the DMA engine.
    logic                  a_req;
    logic                  a_we;
    logic [BUF_ADDR_W-1:0] a_addr;
    logic [WORD_W-1:0]     a_wdata;
    logic                  a_ack;
    logic [WORD_W-1:0]     a_rdata;
    logic                  b_req;
    logic                  b_we;
    logic [BUF_ADDR_W-1:0] b_addr;
    logic [WORD_W-1:0]     b_wdata;
    logic                  b_ack;
    logic [WORD_W-1:0]     b_rdata;

    mcu_spi #(.SYNC_STAGES(SYNC_STAGES)) u_spi (.*);

    link_protocol u_protocol (
        .*,
        .buf_req(a_req), .buf_we(a_we), .buf_addr(a_addr), .buf_wdata(a_wdata),
        .buf_ack(a_ack), .buf_rdata(a_rdata)
    );

    link_registers #(.SYNC_STAGES(SYNC_STAGES)) u_registers (.*);

    buffer_arbiter u_arbiter (.*);

    mem_bus_dma u_dma (
        .*,
        .buf_req(b_req), .buf_we(b_we), .buf_addr(b_addr), .buf_wdata(b_wdata),
        .buf_ack(b_ack), .buf_rdata(b_rdata)
    );

endmodule

// File: verif/tb_link_tasks.svh
`ifndef TB_LINK_TASKS_SVH
`define TB_LINK_TASKS_SVH

// read data that the memory bus model returns for a byte address.
function automatic logic [15:0] bus_word(input logic [31:0] address);
    logic [15:0] product;
    product = address[15:0] * 16'h9e37;
    return product + 16'h1234;
endfunction

// the button and card detect lines are active low, so STATUS shows them inverted.
function automatic logic [31:0] status_word(input logic btn, input logic det);
    return {30'd0, ~det, ~btn};
endfunction

// one SPI mode 0 byte, MSB first, with a half period of 4 clk cycles.
task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
        mcu_mosi <= tx[i];
        repeat (4) @(posedge clk);
        mcu_clk <= 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rx[i] = mcu_miso;  // the slave shifts late, so the end of the high half is safe.
        @(posedge clk);
        mcu_clk <= 1'b0;
    end
    repeat (16) @(posedge clk);
endtask

// sends frame_tx[0..len-1] in one chip select frame and fills frame_rx.
task automatic spi_frame(input int len);
    logic [7:0] rx;
    @(posedge clk);
    mcu_cs <= 1'b0;
    repeat (8) @(posedge clk);
    for (int k = 0; k < len; k++) begin
        spi_byte(frame_tx[k], rx);
        frame_rx[k] = rx;
    end
    mcu_cs <= 1'b1;
    repeat (8) @(posedge clk);
endtask

`endif

// File: verif/mcu_top_tb.sv
`timescale 1ns/1ps

module mcu_top_tb
    import link_pkg::*;
    import buffer_pkg::*;
();
    localparam int TIMEOUT_CYCLES = 200000;

    logic                  clk;
    logic                  reset;
    logic                  sd_det;
    logic                  button;
    logic                  mcu_clk;
    logic                  mcu_cs;
    logic                  mcu_mosi;
    logic                  mcu_miso;
    logic                  mem_request;
    logic                  mem_write;
    logic [BUS_ADDR_W-1:0] mem_address;
    logic [WORD_W-1:0]     mem_wdata;
    logic                  mem_ack;
    logic [WORD_W-1:0]     mem_rdata;

    logic [7:0]        frame_tx [40];
    logic [7:0]        frame_rx [40];
    logic [WORD_W-1:0] words [16];
    logic [WORD_W-1:0] wr_mem [logic [31:0]];  // bus writes by address.
    logic [31:0]       wr_addr_q [$];
    int                ack_delay [256];
    int                ack_index;
    string             chk_name_q [$];
    logic [31:0]       chk_exp_q [$];
    logic [31:0]       chk_act_q [$];
    string             chk_name;
    logic [31:0]       chk_exp;
    logic [31:0]       chk_act;
    int                data_errors;
    int                protocol_errors;
    int                cycles;
    logic              req_prev;
    logic              ack_prev;

    mcu_top #(.SYNC_STAGES(3)) UUT (.*);

    `include "tb_link_tasks.svh"

    always #20 clk = ~clk;

    task automatic expect_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        chk_name_q.push_back(name);
        chk_exp_q.push_back(expected);
        chk_act_q.push_back(actual);
    endtask

    function automatic logic [31:0] scr_word(input logic start, input logic stop,
                                             input logic dir, input int len);
        logic [31:0] word;
        word = 32'd0;
        word[START_BIT] = start;
        word[STOP_BIT] = stop;
        word[DIR_BIT] = dir;
        word[LEN_MSB:LEN_LSB] = len[LEN_MSB-LEN_LSB:0];
        return word;
    endfunction

    task automatic write_register(input logic [7:0] addr, input logic [31:0] value);
        frame_tx[0] = CMD_REG_WRITE;
        frame_tx[1] = addr;
        for (int i = 0; i < 4; i++) begin
            frame_tx[2 + i] = value[8 * i +: 8];  // little-endian.
        end
        spi_frame(6);
    endtask

    task automatic read_register(input logic [7:0] addr, output logic [31:0] value);
        frame_tx[0] = CMD_REG_READ;
        frame_tx[1] = addr;
        for (int i = 0; i < 4; i++) begin
            frame_tx[2 + i] = 8'h00;
        end
        spi_frame(6);
        for (int i = 0; i < 4; i++) begin
            value[8 * i +: 8] = frame_rx[2 + i];
        end
    endtask

    // the address byte selects word index 2 * addr_byte.
    task automatic write_buffer(input logic [7:0] addr_byte, input int n);
        frame_tx[0] = CMD_MEM_WRITE;
        frame_tx[1] = addr_byte;
        for (int i = 0; i < n; i++) begin
            frame_tx[2 + 2 * i] = words[i][15:8];
            frame_tx[3 + 2 * i] = words[i][7:0];
        end
        spi_frame(2 + 2 * n);
    endtask

    task automatic read_buffer(input logic [7:0] addr_byte, input int n);
        frame_tx[0] = CMD_MEM_READ;
        frame_tx[1] = addr_byte;
        for (int i = 0; i < 2 * n; i++) begin
            frame_tx[2 + i] = 8'h00;
        end
        spi_frame(2 + 2 * n);
        for (int i = 0; i < n; i++) begin
            expect_value("buf_rdata", 32'(words[i]),
                         32'({frame_rx[2 + 2 * i], frame_rx[3 + 2 * i]}));
        end
    endtask

    task automatic wait_dma_idle();
        logic [31:0] scr;
        int          polls;
        scr = 32'hffff_ffff;
        polls = 0;
        while (scr[BUSY_BIT] !== 1'b0 && polls < 40) begin
            read_register(REG_MEM_SCR, scr);
            polls++;
        end
        expect_value("MEM_SCR busy", 32'd0, 32'(scr[BUSY_BIT]));
    endtask

    task automatic print_summary();
        $display("errors: %0d data, %0d protocol", data_errors, protocol_errors);
    endtask

    // memory bus model with a random ack delay of 0 to 5 cycles.
    always @(posedge clk) begin
        if (mem_request && !mem_ack) begin
            repeat (ack_delay[ack_index]) @(posedge clk);
            ack_index = (ack_index + 1) % 256;
            if (mem_write) begin
                wr_mem[mem_address] = mem_wdata;
                wr_addr_q.push_back(mem_address);
            end
            mem_ack <= 1'b1;
            mem_rdata <= bus_word(mem_address);
            @(posedge clk);
            while (mem_request) begin
                @(posedge clk);
            end
            mem_ack <= 1'b0;
        end
    end

    always @(negedge clk) begin
        if (chk_act_q.size() > 0) begin
            chk_name = chk_name_q.pop_front();
            chk_exp = chk_exp_q.pop_front();
            chk_act = chk_act_q.pop_front();
            if (chk_act !== chk_exp) begin
                data_errors++;
                $display("[FAIL] %0t %s expected %h got %h", $time, chk_name, chk_exp, chk_act);
            end
        end
        if (!reset && mem_request && !req_prev && (mem_ack || ack_prev)) begin
            protocol_errors++;
            $display("mem_request rose while mem_ack was high at %0t", $time);
        end
        if (!reset && req_prev && !mem_request && !ack_prev) begin
            protocol_errors++;
            $display("mem_request dropped before mem_ack at %0t", $time);
        end
        req_prev = mem_request;
        ack_prev = mem_ack;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the test sequence did not finish in %0d cycles", cycles);
            print_summary();
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] value;
        logic [31:0] result;
        logic [31:0] base;
        int          n;
        clk = 1'b0;
        reset = 1'b1;
        sd_det = 1'b1;
        button = 1'b1;
        mcu_clk = 1'b0;
        mcu_cs = 1'b1;
        mcu_mosi = 1'b0;
        mem_ack = 1'b0;
        mem_rdata = '0;
        ack_index = 0;
        data_errors = 0;
        protocol_errors = 0;
        cycles = 0;
        void'($urandom(32'hb323));
        for (int i = 0; i < 256; i++) begin
            ack_delay[i] = $urandom % 6;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        expect_value("mem_request", 32'd0, 32'(mem_request));
        expect_value("mcu_miso", 32'd0, 32'(mcu_miso));

        frame_tx[0] = CMD_IDENTIFY;
        frame_tx[1] = 8'h00;
        spi_frame(2);
        expect_value("identify id", 32'(DEVICE_ID), 32'(frame_rx[1]));

        value = $urandom;
        write_register(REG_MEM_ADDRESS, value);
        read_register(REG_MEM_ADDRESS, result);
        expect_value("MEM_ADDRESS", value, result);
        value = $urandom;
        @(posedge clk);
        button <= value[0];
        sd_det <= value[1];
        repeat (10) @(posedge clk);
        read_register(REG_STATUS, result);
        expect_value("STATUS", status_word(value[0], value[1]), result);

        n = 1 + $urandom % 16;
        value = $urandom;
        for (int i = 0; i < n; i++) begin
            words[i] = 16'($urandom);
        end
        write_buffer(value[7:0], n);
        read_buffer(value[7:0], n);

        // the DMA engine always starts at buffer word 0.
        n = 1 + $urandom % 16;
        base = $urandom & 32'hffff_fffe;
        for (int i = 0; i < n; i++) begin
            words[i] = 16'($urandom);
        end
        write_buffer(8'h00, n);
        write_register(REG_MEM_ADDRESS, base);
        wr_mem.delete();
        wr_addr_q.delete();
        write_register(REG_MEM_SCR, scr_word(1'b1, 1'b0, 1'b1, n));
        wait_dma_idle();
        expect_value("bus write count", n, wr_addr_q.size());
        for (int i = 0; i < n && i < wr_addr_q.size(); i++) begin
            expect_value("mem_address", base + 32'(2 * i), wr_addr_q[i]);
            expect_value("mem_wdata", 32'(words[i]), 32'(wr_mem[base + 32'(2 * i)]));
        end

        n = 1 + $urandom % 16;
        base = $urandom & 32'hffff_fffe;
        write_register(REG_MEM_ADDRESS, base);
        wr_addr_q.delete();
        write_register(REG_MEM_SCR, scr_word(1'b1, 1'b0, 1'b0, n));
        wait_dma_idle();
        expect_value("bus write count", 32'd0, wr_addr_q.size());  // a bus read writes nothing.
        for (int i = 0; i < n; i++) begin
            words[i] = bus_word(base + 32'(2 * i));
        end
        read_buffer(8'h00, n);

        wr_mem.delete();
        wr_addr_q.delete();
        write_register(REG_MEM_SCR, scr_word(1'b1, 1'b0, 1'b1, 512));
        read_register(REG_MEM_SCR, result);
        expect_value("MEM_SCR busy", 32'd1, 32'(result[BUSY_BIT]));
        write_register(REG_MEM_SCR, scr_word(1'b0, 1'b1, 1'b0, 0));
        wait_dma_idle();
        // the stop lands a few hundred words into the transfer at most.
        if (wr_addr_q.size() >= 512) begin
            data_errors++;
            $display("[FAIL] %0t bus write count expected below 512 got %0d",
                     $time, wr_addr_q.size());
        end

        repeat (4) @(posedge clk);
        while (chk_act_q.size() > 0) begin
            @(negedge clk);
        end
        print_summary();
        if (data_errors == 0 && protocol_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+verif
verilog/link_pkg.sv
verilog/buffer_pkg.sv
verilog/mcu_spi.sv
verilog/link_protocol.sv
verilog/link_registers.sv
verilog/buffer_arbiter.sv
verilog/mem_bus_dma.sv
verilog/mcu_top.sv
verif/mcu_top_tb.sv
